// File: hw/readout_pkg.sv
// shared widths, sizes and bundle types of the readout merger
// import with readout_pkg::* in the module body; scoped names in port lists
package readout_pkg;

    // channel and word geometry
    localparam int NUM_CHAN   = 4;
    localparam int DATA_W     = 32;

    // per-channel buffer
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH); // wraps on its own, depth is 2**n
    localparam int FILL_W     = 4;                  // 0 .. FIFO_DEPTH inclusive
    localparam int HOLD_LEVEL = 6;                  // fill at which priority is asked for

    // one data word as seen on every path
    typedef logic [DATA_W-1:0] data_word_t;

    // one bit per channel: requests, holds, grants, one-hot select
    typedef logic [NUM_CHAN-1:0] chan_mask_t;

    // buffer fill count
    typedef logic [FILL_W-1:0] fill_t;

    // source to buffer, ack comes back on its own wire
    typedef struct packed {
        logic       req;  // four-phase request
        data_word_t data; // held stable while req is high
    } chan_push_t;

    // merger to consumer, out_ack comes back on its own wire
    typedef struct packed {
        logic       req;  // four-phase request
        data_word_t data; // valid while req is high
    } out_word_t;

endpackage

// File: hw/chan_buffer.sv
// one readout channel: four-phase input port, show-ahead FIFO and hold request
// head/not_empty feed the arbiter; a pop in the grant cycle removes the head
`timescale 1ns/100ps

module chan_buffer (
    input  logic                    CLK,
    input  logic                    RST,
    input  readout_pkg::chan_push_t push,
    output logic                    push_ack,
    input  logic                    pop,
    output readout_pkg::data_word_t head,
    output logic                    not_empty,
    output logic                    hold_req
);
    import readout_pkg::*;

    typedef enum logic {
        S_IDLE,  // waiting for req
        S_ACKED  // word taken, waiting for req low
    } in_state_t;

    in_state_t        state;
    data_word_t       mem [FIFO_DEPTH]; // payload only
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fill_t            fill;
    logic             full;
    logic             wr_en;

    assign full  = (fill == fill_t'(FIFO_DEPTH));
    assign wr_en = (state == S_IDLE) && push.req && !full; // full -> ack withheld

    // input handshake
    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (wr_en) state <= S_ACKED;
                S_ACKED: if (!push.req) state <= S_IDLE; // ack falls next cycle
                default: state <= S_IDLE;
            endcase
        end
    end

    assign push_ack = (state == S_ACKED);

    // storage
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= push.data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (pop)   rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !pop) begin
                fill <= fill + 1'b1;
            end else if (!wr_en && pop) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // show-ahead head, visible the cycle after the write
    assign head      = mem[rd_ptr];
    assign not_empty = (fill != '0);
    assign hold_req  = (fill >= fill_t'(HOLD_LEVEL)); // priority above high water

    // arbiter must only grant a channel that has data
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RST)
        pop |-> not_empty);

    a_fill_bound: assert property (@(posedge CLK) disable iff (RST)
        fill <= fill_t'(FIFO_DEPTH));

endmodule

// File: hw/rrp_arbiter.sv
// round-robin arbiter over the channel buffers with a hold (priority) override
// lowest channel with hold_req wins; otherwise search upward from last pick
// grant lasts one cycle in a ready cycle and drives write_out and data_out
`timescale 1ns/100ps

module rrp_arbiter (
    input  logic                    CLK,
    input  logic                    RST,
    input  readout_pkg::chan_mask_t write_req,
    input  readout_pkg::chan_mask_t hold_req,
    input  readout_pkg::data_word_t data_in [readout_pkg::NUM_CHAN],
    output readout_pkg::chan_mask_t read_grant,
    input  logic                    ready,
    output logic                    write_out,
    output readout_pkg::data_word_t data_out
);
    import readout_pkg::*;

    chan_mask_t prev_select; // one-hot last channel served
    chan_mask_t select;      // one hot
    logic       hold;        // selection frozen while the output is busy
    logic       any_req;
    logic       any_hold;

    assign any_req  = |write_req;
    assign any_hold = |hold_req;

    // one-hot select
    always_comb begin
        chan_mask_t rot;
        logic       found;

        select = prev_select;
        rot    = prev_select;
        found  = 1'b0;
        if (any_hold && !hold) begin
            // walk down so the lowest holding channel is the one left
            select = '0;
            for (int i = NUM_CHAN - 1; i >= 0; i--) begin
                if (hold_req[i]) begin
                    select = chan_mask_t'(1) << i;
                end
            end
        end else if (any_req && !hold) begin
            for (int k = 0; k < NUM_CHAN; k++) begin
                rot = {rot[NUM_CHAN-2:0], rot[NUM_CHAN-1]}; // next channel up with wrap
                if (!found && |(rot & write_req)) begin
                    select = rot;
                    found  = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            prev_select <= chan_mask_t'(1) << (NUM_CHAN - 1); // first rr pick is ch 0
        end else if (any_req && !hold) begin
            prev_select <= select;
        end
    end

    // set on a transfer and dropped once the output frees its register
    always_ff @(posedge CLK) begin
        if (RST) begin
            hold <= 1'b0;
        end else if (write_out) begin
            hold <= 1'b1;
        end else if (ready) begin
            hold <= 1'b0;
        end
    end

    // no grant in the cycle ready returns while hold is still set
    assign read_grant = select & {NUM_CHAN{ready && !hold && any_req}};
    assign write_out  = |read_grant;

    // and-or data mux over the one-hot select
    always_comb begin
        data_out = '0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            data_out = data_out | (data_in[i] & {DATA_W{select[i]}});
        end
    end

    a_grant_onehot: assert property (@(posedge CLK) disable iff (RST)
        $onehot0(read_grant));

    // grant lands on a channel that asked
    a_grant_req: assert property (@(posedge CLK) disable iff (RST)
        |read_grant |-> |(read_grant & write_req));

endmodule

// File: hw/out_port.sv
// output word register and four-phase sender towards the consumer
// ready is high while the register is free; write captures data at the edge
`timescale 1ns/100ps

module out_port (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    write,
    input  readout_pkg::data_word_t data,
    output logic                    ready,
    output readout_pkg::out_word_t  out,
    input  logic                    out_ack
);
    import readout_pkg::*;

    typedef enum logic [1:0] {
        S_EMPTY,    // register free
        S_REQ,      // req high until ack
        S_ACK_LOW   // req dropped until ack falls
    } out_state_t;

    out_state_t state;
    data_word_t word_q; // word under transfer

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= S_EMPTY;
        end else begin
            case (state)
                S_EMPTY: begin
                    if (write) state <= S_REQ; // req up next cycle
                end
                S_REQ: begin
                    if (out_ack) state <= S_ACK_LOW;
                end
                S_ACK_LOW: begin
                    if (!out_ack) state <= S_EMPTY; // release register
                end
                default: state <= S_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (write && state == S_EMPTY) begin
            word_q <= data;
        end
    end

    assign ready = (state == S_EMPTY);
    assign out   = '{req: (state == S_REQ), data: word_q};

    // data held for the whole request
    a_data_stable: assert property (@(posedge CLK) disable iff (RST)
        out.req && $past(out.req) |-> $stable(out.data));

    // arbiter may only write into a free register
    a_write_ready: assert property (@(posedge CLK) disable iff (RST)
        write |-> ready);

endmodule

// File: hw/readout_merger_top.sv
// readout merger: four buffered channel inputs merged into one output stream
// channel sources and consumer both talk four-phase req/ack
`timescale 1ns/100ps

module readout_merger_top (
    input  logic                    CLK,
    input  logic                    RST,
    input  readout_pkg::chan_push_t chan_push [readout_pkg::NUM_CHAN],
    output readout_pkg::chan_mask_t chan_ack,
    output readout_pkg::out_word_t  out,
    input  logic                    out_ack
);
    import readout_pkg::*;

    chan_mask_t not_empty;            // -> write_req
    chan_mask_t hold;                 // -> hold_req
    chan_mask_t grant;                // pop per channel
    data_word_t head [NUM_CHAN];      // show-ahead words
    logic       write_out;
    logic       ready;
    data_word_t merged;

    // channel buffers
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        chan_buffer u_buf (
            .CLK       (CLK),
            .RST       (RST),
            .push      (chan_push[i]),
            .push_ack  (chan_ack[i]),
            .pop       (grant[i]),
            .head      (head[i]),
            .not_empty (not_empty[i]),
            .hold_req  (hold[i])
        );
    end

    rrp_arbiter u_arb (
        .CLK        (CLK),
        .RST        (RST),
        .write_req  (not_empty),
        .hold_req   (hold),
        .data_in    (head),
        .read_grant (grant),
        .ready      (ready),
        .write_out  (write_out),
        .data_out   (merged)
    );

    // single output register
    out_port u_out (
        .CLK     (CLK),
        .RST     (RST),
        .write   (write_out),
        .data    (merged),
        .ready   (ready),
        .out     (out),
        .out_ack (out_ack)
    );

endmodule

// File: tb/tb_readout_merger.sv
// directed testbench for the readout merger
// four-phase sources on each channel and a four-phase consumer with selectable ack delay
// expected output order is rebuilt from the arbitration rules and compared word by word
`timescale 1ns/100ps

module tb_readout_merger;
    import readout_pkg::*;

    localparam int HALF_PERIOD = 50;   // 100 ns clock
    localparam int DRIVE_DLY   = 2;    // inputs change this long after the edge
    localparam int RESET_CYC   = 16;
    localparam int MAX_CYCLES  = 4000; // about twice the summed test lengths
    localparam int CH_W        = 4;    // channel tag in the top bits
    localparam int SEQ_W       = 8;    // per-channel sequence number
    localparam int PAY_W       = DATA_W - CH_W - SEQ_W; // random filler

    logic        CLK;
    logic        RST;
    chan_push_t  chan_push [NUM_CHAN];
    chan_mask_t  chan_ack;
    out_word_t   out_word;
    logic        out_ack;

    logic [31:0] lfsr_state  = 32'h79e6;
    int          seq_no [NUM_CHAN] = '{default: 0};
    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    data_word_t  pushed [$];   // every word handed to a channel in push order
    data_word_t  expected [$];
    data_word_t  received [$]; // words seen by the consumer

    readout_merger_top DUT (
        .CLK       (CLK),
        .RST       (RST),
        .chan_push (chan_push),
        .chan_ack  (chan_ack),
        .out       (out_word),
        .out_ack   (out_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // watchdog
    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("checks run: %0d, errors: %0d", checks, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [PAY_W-1:0] random_bits();
        logic [PAY_W-1:0] bits;
        for (int i = 0; i < PAY_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            bits[i]    = lfsr_state[0];
        end
        return bits;
    endfunction

    // channel tag, sequence number, random payload
    function automatic data_word_t make_word(input int ch);
        data_word_t w;
        w = {CH_W'(ch), SEQ_W'(seq_no[ch]), random_bits()};
        seq_no[ch]++;
        return w;
    endfunction

    function automatic int chan_of(input data_word_t w);
        return int'(w[DATA_W-1 -: CH_W]);
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // lands just after the next rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_DLY;
    endtask

    // completes a push whose req is already up
    task automatic finish_push(input int ch);
        do next_cycle(); while (!chan_ack[ch]);
        chan_push[ch] = '{req: 1'b0, data: chan_push[ch].data};
        do next_cycle(); while (chan_ack[ch]);
    endtask

    task automatic push_words(input int ch, input int n);
        data_word_t w;
        for (int i = 0; i < n; i++) begin
            w             = make_word(ch);
            chan_push[ch] = '{req: 1'b1, data: w};
            pushed.push_back(w);
            finish_push(ch);
        end
    endtask

    // consumer takes n words and acks each after ack_delay cycles
    task automatic consume_words(input int n, input int ack_delay);
        for (int i = 0; i < n; i++) begin
            while (!out_word.req) next_cycle();
            received.push_back(out_word.data);
            repeat (ack_delay) next_cycle();
            out_ack = 1'b1;
            do next_cycle(); while (out_word.req); // req drops after ack
            out_ack = 1'b0;
        end
    endtask

    // expected order when every word was pushed with the consumer stalled;
    // the first push lands straight in the output register
    task automatic model_order();
        data_word_t pend [$];
        int         cnt [NUM_CHAN];
        int         last;
        int         pick;
        int         idx;
        pend     = pushed;
        expected = {};
        expected.push_back(pend[0]);
        last = chan_of(pend[0]);
        pend.delete(0);
        cnt = '{default: 0};
        foreach (pend[i]) cnt[chan_of(pend[i])]++;
        while (pend.size() > 0) begin
            pick = -1;
            for (int c = NUM_CHAN - 1; c >= 0; c--) begin
                if (cnt[c] >= HOLD_LEVEL) pick = c; // lowest high-water channel wins
            end
            for (int k = 1; k <= NUM_CHAN; k++) begin
                if (pick < 0 && cnt[(last + k) % NUM_CHAN] > 0) pick = (last + k) % NUM_CHAN;
            end
            idx = 0;
            while (chan_of(pend[idx]) != pick) idx++; // oldest word of that channel
            expected.push_back(pend[idx]);
            pend.delete(idx);
            cnt[pick]--;
            last = pick;
        end
    endtask

    task automatic compare_streams(input string name);
        check_value({name, " word count"}, expected.size(), received.size());
        for (int i = 0; i < expected.size() && i < received.size(); i++) begin
            check_value($sformatf("%s word %0d", name, i), expected[i], received[i]);
        end
        repeat (10) next_cycle();
        check_value({name, " no extra word"}, 0, out_word.req); // nothing duplicated
        pushed   = {};
        expected = {};
        received = {};
    endtask

    task automatic reset_values();
        check_value("reset out req", 0, out_word.req);
        check_value("reset chan ack", 0, chan_ack);
    endtask

    task automatic single_channel();
        fork
            push_words(1, 5);
            consume_words(5, 2);
        join
        expected = pushed; // one source keeps push order
        compare_streams("single channel");
    endtask

    task automatic round_robin();
        for (int ch = 0; ch < NUM_CHAN; ch++) push_words(ch, 2); // consumer stalled
        check_value("round robin first channel", 0, chan_of(out_word.data));
        consume_words(2 * NUM_CHAN, 1);
        model_order();
        compare_streams("round robin");
    endtask

    task automatic priority_drain();
        push_words(0, 1); // goes to the output register
        push_words(3, 1);
        push_words(2, 7); // above high water
        consume_words(9, 3);
        model_order();
        compare_streams("priority");
    endtask

    task automatic back_pressure();
        data_word_t w;
        push_words(0, FIFO_DEPTH + 1); // full buffer plus output register
        w            = make_word(0);
        chan_push[0] = '{req: 1'b1, data: w};
        pushed.push_back(w);
        repeat (20) begin
            next_cycle();
            check_value("back pressure ack held", 0, chan_ack[0]);
        end
        fork
            consume_words(FIFO_DEPTH + 2, 1);
            finish_push(0); // accepted once a slot frees
        join
        expected = pushed;
        compare_streams("back pressure");
    endtask

    initial begin
        RST     = 1'b1;
        out_ack = 1'b0;
        for (int ch = 0; ch < NUM_CHAN; ch++) chan_push[ch] = '0;
        repeat (RESET_CYC) @(posedge CLK);
        #DRIVE_DLY;
        RST = 1'b0;
        next_cycle();

        reset_values();
        single_channel();
        round_robin();
        priority_drain();
        back_pressure();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/readout_pkg.sv
hw/chan_buffer.sv
hw/rrp_arbiter.sv
hw/out_port.sv
hw/readout_merger_top.sv
tb/tb_readout_merger.sv

// File: Bender.yml
package:
  name: readout_merger

sources:
  # package first, then RTL
  - files:
      - hw/readout_pkg.sv
      - hw/chan_buffer.sv
      - hw/rrp_arbiter.sv
      - hw/out_port.sv
      - hw/readout_merger_top.sv
  # testbench
  - target: simulation
    files:
      - tb/tb_readout_merger.sv
